//--- common/arch_pkg.sv
package arch_pkg;

	// ====================
	// register file
	// ====================
	localparam int AREG_IDX_W   = 5;
	localparam int ARCH_REG_NUM = 32;
	localparam logic [AREG_IDX_W-1:0] ZERO_REG = 5'd31; // r31 reads as zero, never renamed

	// ====================
	// instruction fields
	// ====================
	localparam int OP_W       = 6;  // major opcode width
	localparam int OP_LSB     = 26; // opcode sits in [31:26]
	localparam int RA_LSB     = 21; // ra in [25:21]
	localparam int RB_LSB     = 16; // rb in [20:16]
	localparam int RC_LSB     = 0;  // rc in [4:0], operate format only
	localparam int PAL_FUNC_W = 26; // CALL_PAL function code below the opcode

	// ====================
	// opcodes
	// ====================
	localparam logic [OP_W-1:0] OP_PAL  = 6'h00; // CALL_PAL
	localparam logic [OP_W-1:0] OP_INTA = 6'h10; // integer arithmetic
	localparam logic [OP_W-1:0] OP_INTL = 6'h11; // integer logical
	localparam logic [OP_W-1:0] OP_INTS = 6'h12; // integer shift
	localparam logic [OP_W-1:0] OP_INTM = 6'h13; // integer multiply
	localparam logic [OP_W-1:0] OP_LDQ  = 6'h29; // load quadword

	// PAL function codes
	localparam logic [PAL_FUNC_W-1:0] PAL_HALT = 26'h0;

endpackage

//--- common/core_pkg.sv
package core_pkg;

	// ====================
	// physical registers
	// ====================
	localparam int PRF_IDX_W = 6; // enough for up to 64 physical tags

	typedef logic [PRF_IDX_W-1:0] preg_t;

	// error status reported on status_o
	typedef enum logic [1:0] {
		NO_ERROR          = 2'd0,
		HALTED_ON_HALT    = 2'd1,
		HALTED_ON_ILLEGAL = 2'd2
	} status_t;

	// ====================
	// ROB entry
	// ====================
	typedef struct packed {
		logic [arch_pkg::AREG_IDX_W-1:0] dest_idx; // arch dest or r31 when none
		logic                            has_dest; // frees old_tag at retire
		preg_t                           new_tag;  // Tnew from free list
		preg_t                           old_tag;  // Told from map table
		logic                            done;     // completion seen
		logic                            halt;     // CALL_PAL halt
		logic                            illegal;  // undecodable word
	} rob_entry_t;

endpackage

//--- source/id_stage.sv
`timescale 1ns/1ns

module id_stage (
	input  logic                            inst_vld_i,
	input  logic [31:0]                     inst_ir_i,
	input  logic                            rob_full_i,
	input  logic                            fl_empty_i,
	input  logic                            halted_i,

	output logic [arch_pkg::AREG_IDX_W-1:0] ra_idx_o,
	output logic [arch_pkg::AREG_IDX_W-1:0] rb_idx_o,
	output logic [arch_pkg::AREG_IDX_W-1:0] dest_idx_o,
	output logic                            halt_o,
	output logic                            illegal_o,
	output logic                            dispatch_en_o,
	output logic                            alloc_en_o,
	output logic                            dispatch_stall_o
);

	logic [arch_pkg::OP_W-1:0]       opcode;
	logic [arch_pkg::AREG_IDX_W-1:0] ra_fld;
	logic [arch_pkg::AREG_IDX_W-1:0] rb_fld;
	logic [arch_pkg::AREG_IDX_W-1:0] rc_fld;
	logic                            has_dest;

	// raw fields, meaning depends on format
	assign opcode = inst_ir_i[arch_pkg::OP_LSB +: arch_pkg::OP_W];
	assign ra_fld = inst_ir_i[arch_pkg::RA_LSB +: arch_pkg::AREG_IDX_W];
	assign rb_fld = inst_ir_i[arch_pkg::RB_LSB +: arch_pkg::AREG_IDX_W];
	assign rc_fld = inst_ir_i[arch_pkg::RC_LSB +: arch_pkg::AREG_IDX_W];

	// ====================
	// decoder
	// ====================
	always_comb begin
		ra_idx_o   = arch_pkg::ZERO_REG; // unused sources read r31
		rb_idx_o   = arch_pkg::ZERO_REG;
		dest_idx_o = arch_pkg::ZERO_REG; // no dest unless set below
		halt_o     = 1'b0;
		illegal_o  = 1'b0;
		case (opcode)
			arch_pkg::OP_INTA,
			arch_pkg::OP_INTL,
			arch_pkg::OP_INTS,
			arch_pkg::OP_INTM: begin
				ra_idx_o   = ra_fld;
				rb_idx_o   = rb_fld;
				dest_idx_o = rc_fld; // operate writes rc
			end
			arch_pkg::OP_LDQ: begin
				rb_idx_o   = rb_fld; // base register
				dest_idx_o = ra_fld; // load target is ra
			end
			arch_pkg::OP_PAL: begin
				// only halt is supported among PAL calls
				if (inst_ir_i[arch_pkg::PAL_FUNC_W-1:0] == arch_pkg::PAL_HALT)
					halt_o = 1'b1;
				else
					illegal_o = 1'b1;
			end
			default: illegal_o = 1'b1;
		endcase
	end

	// ====================
	// dispatch control
	// ====================
	assign has_dest = (dest_idx_o != arch_pkg::ZERO_REG);

	// a free tag is only needed by writers
	assign dispatch_stall_o = rob_full_i | (fl_empty_i & has_dest) | halted_i;
	assign dispatch_en_o    = inst_vld_i & ~dispatch_stall_o;
	assign alloc_en_o       = dispatch_en_o & has_dest; // pops free list, writes map

endmodule

//--- rename/map_table.sv
`timescale 1ns/1ns

module map_table #(
	parameter int PRF_NUM = 40
) (
	input  logic                            clk,
	input  logic                            rst_n_i,

	input  logic [arch_pkg::AREG_IDX_W-1:0] ra_idx_i,
	input  logic [arch_pkg::AREG_IDX_W-1:0] rb_idx_i,
	input  logic [arch_pkg::AREG_IDX_W-1:0] dest_idx_i,
	input  logic                            alloc_en_i,
	input  core_pkg::preg_t                 new_tag_i,

	output core_pkg::preg_t                 opa_tag_o,
	output core_pkg::preg_t                 opb_tag_o,
	output core_pkg::preg_t                 old_tag_o
);

	core_pkg::preg_t map_q [arch_pkg::ARCH_REG_NUM]; // arch reg -> current tag

	// reads see the mapping before this cycle's write
	assign opa_tag_o = map_q[ra_idx_i];
	assign opb_tag_o = map_q[rb_idx_i];
	assign old_tag_o = map_q[dest_idx_i]; // Told, goes to the ROB

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			// identity map out of reset
			for (int i = 0; i < arch_pkg::ARCH_REG_NUM; i++)
				map_q[i] <= core_pkg::preg_t'(i);
		end else if (alloc_en_i) begin
			map_q[dest_idx_i] <= new_tag_i; // Tnew becomes the live mapping
		end
	end

	// ====================
	// checks
	// ====================
	// decoder must never hand r31 to rename
	assert property (@(posedge clk) disable iff (!rst_n_i)
		alloc_en_i |-> dest_idx_i != arch_pkg::ZERO_REG)
		else $error("map_table: write to zero register");

	// free list only ever holds tags that exist
	assert property (@(posedge clk) disable iff (!rst_n_i)
		alloc_en_i |-> int'(new_tag_i) < PRF_NUM)
		else $error("map_table: new tag %0d out of range", new_tag_i);

endmodule

//--- rename/free_list.sv
`timescale 1ns/1ns

module free_list #(
	parameter int PRF_NUM = 40
) (
	input  logic            clk,
	input  logic            rst_n_i,

	input  logic            alloc_en_i, // pop head
	input  logic            free_en_i,  // push at tail
	input  core_pkg::preg_t free_tag_i,

	output core_pkg::preg_t head_tag_o,
	output logic            empty_o
);

	localparam int FL_DEPTH = PRF_NUM - arch_pkg::ARCH_REG_NUM; // tags not mapped at reset
	localparam int FL_PTR_W = (FL_DEPTH > 1) ? $clog2(FL_DEPTH) : 1;
	localparam int FL_CNT_W = $clog2(FL_DEPTH + 1);

	core_pkg::preg_t     fl_mem [FL_DEPTH];
	logic [FL_PTR_W-1:0] head_q;
	logic [FL_PTR_W-1:0] tail_q;
	logic [FL_CNT_W-1:0] count_q;
	logic                full;

	assign head_tag_o = fl_mem[head_q]; // next Tnew, visible before the pop
	assign empty_o    = (count_q == '0);
	assign full       = (count_q == FL_CNT_W'(FL_DEPTH));

	// ====================
	// queue state
	// ====================
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			head_q  <= '0;
			tail_q  <= '0; // full queue, tail wrapped onto head
			count_q <= FL_CNT_W'(FL_DEPTH);
			for (int i = 0; i < FL_DEPTH; i++)
				fl_mem[i] <= core_pkg::preg_t'(arch_pkg::ARCH_REG_NUM + i);
		end else begin
			if (alloc_en_i) begin
				head_q <= (head_q == FL_PTR_W'(FL_DEPTH - 1)) ? '0 : head_q + 1'b1;
			end
			if (free_en_i) begin
				fl_mem[tail_q] <= free_tag_i; // Told from retirement
				tail_q         <= (tail_q == FL_PTR_W'(FL_DEPTH - 1)) ? '0 : tail_q + 1'b1;
			end
			// pop and push together leave the count alone
			case ({alloc_en_i, free_en_i})
				2'b10:   count_q <= count_q - 1'b1;
				2'b01:   count_q <= count_q + 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// ====================
	// checks
	// ====================
	// dispatch stall has to cover the empty case
	assert property (@(posedge clk) disable iff (!rst_n_i)
		alloc_en_i |-> !empty_o)
		else $error("free_list: pop while empty");

	// tags are conserved, a full list means nothing is in flight to free
	assert property (@(posedge clk) disable iff (!rst_n_i)
		free_en_i |-> !full)
		else $error("free_list: push while full");

endmodule

//--- rob/rob.sv
`timescale 1ns/1ns

module rob #(
	parameter  int ROB_DEPTH = 16,
	localparam int ROB_IDX_W = $clog2(ROB_DEPTH)
) (
	input  logic                            clk,
	input  logic                            rst_n_i,

	// dispatch side
	input  logic                            dispatch_en_i,
	input  logic [arch_pkg::AREG_IDX_W-1:0] dest_idx_i,
	input  logic                            halt_i,
	input  logic                            illegal_i,
	input  core_pkg::preg_t                 new_tag_i,
	input  core_pkg::preg_t                 old_tag_i,

	// completion from the execution side
	input  logic                            complete_vld_i,
	input  logic [ROB_IDX_W-1:0]            complete_rob_idx_i,

	output logic [ROB_IDX_W-1:0]            tail_idx_o,
	output logic                            full_o,
	output logic                            halted_o,

	// retirement
	output logic                            retire_vld_o,
	output logic [arch_pkg::AREG_IDX_W-1:0] retire_dest_idx_o,
	output core_pkg::preg_t                 retire_dest_tag_o,
	output core_pkg::preg_t                 retire_old_tag_o,
	output logic                            free_en_o,
	output core_pkg::status_t               status_o
);

	localparam int ROB_CNT_W = ROB_IDX_W + 1;

	core_pkg::rob_entry_t rob_q [ROB_DEPTH];
	core_pkg::rob_entry_t new_ent;
	core_pkg::rob_entry_t head_ent;

	logic [ROB_IDX_W-1:0] head_q;
	logic [ROB_IDX_W-1:0] tail_q;
	logic [ROB_CNT_W-1:0] count_q;
	logic                 halted_q;
	core_pkg::status_t    status_q;
	logic [ROB_IDX_W-1:0] cpl_ofs; // distance of completing slot from head

	// ====================
	// entry write
	// ====================
	always_comb begin
		new_ent          = '0;
		new_ent.dest_idx = dest_idx_i;
		new_ent.has_dest = (dest_idx_i != arch_pkg::ZERO_REG);
		new_ent.new_tag  = new_tag_i;
		new_ent.old_tag  = old_tag_i;
		new_ent.done     = 1'b0; // waits for completion pulse
		new_ent.halt     = halt_i;
		new_ent.illegal  = illegal_i;
	end

	// payload only, occupancy lives in head/count
	always_ff @(posedge clk) begin
		if (dispatch_en_i)
			rob_q[tail_q] <= new_ent;
		if (complete_vld_i)
			rob_q[complete_rob_idx_i].done <= 1'b1;
	end

	// ====================
	// head and retire
	// ====================
	assign head_ent = rob_q[head_q];

	// one retire per cycle, frozen once halted
	assign retire_vld_o      = (count_q != '0) & head_ent.done & ~halted_q;
	assign retire_dest_idx_o = head_ent.dest_idx;
	assign retire_dest_tag_o = head_ent.new_tag;
	assign retire_old_tag_o  = head_ent.old_tag;
	assign free_en_o         = retire_vld_o & head_ent.has_dest; // Told back to free list

	assign tail_idx_o = tail_q; // rob index of the dispatching insn
	assign full_o     = (count_q == ROB_CNT_W'(ROB_DEPTH));
	assign halted_o   = halted_q;
	assign status_o   = status_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			head_q   <= '0;
			tail_q   <= '0;
			count_q  <= '0;
			halted_q <= 1'b0;
			status_q <= core_pkg::NO_ERROR;
		end else begin
			if (dispatch_en_i)
				tail_q <= tail_q + 1'b1; // depth is a power of two, wraps for free
			if (retire_vld_o) begin
				head_q <= head_q + 1'b1;
				// halt or illegal reaching the head stops the machine
				if (head_ent.illegal) begin
					halted_q <= 1'b1;
					status_q <= core_pkg::HALTED_ON_ILLEGAL;
				end else if (head_ent.halt) begin
					halted_q <= 1'b1;
					status_q <= core_pkg::HALTED_ON_HALT;
				end
			end
			case ({dispatch_en_i, retire_vld_o})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// ====================
	// checks
	// ====================
	assign cpl_ofs = complete_rob_idx_i - head_q;

	// execution unit may only complete a live entry, and only once
	assert property (@(posedge clk) disable iff (!rst_n_i)
		complete_vld_i |-> ({1'b0, cpl_ofs} < count_q) && !rob_q[complete_rob_idx_i].done)
		else $error("rob: bad completion at index %0d", complete_rob_idx_i);

endmodule

//--- source/rename_core.sv
`timescale 1ns/1ns

module rename_core #(
	parameter  int PRF_NUM   = 40,
	parameter  int ROB_DEPTH = 16,
	localparam int ROB_IDX_W = $clog2(ROB_DEPTH)
) (
	input  logic                            clk,
	input  logic                            rst_n_i,

	input  logic                            inst_vld_i,
	input  logic [31:0]                     inst_ir_i,
	input  logic                            complete_vld_i,
	input  logic [ROB_IDX_W-1:0]            complete_rob_idx_i,

	output logic                            dispatch_stall_o,
	output core_pkg::preg_t                 rn_dest_tag_o,
	output core_pkg::preg_t                 rn_opa_tag_o,
	output core_pkg::preg_t                 rn_opb_tag_o,
	output logic [ROB_IDX_W-1:0]            rn_rob_idx_o,
	output logic                            retire_vld_o,
	output logic [arch_pkg::AREG_IDX_W-1:0] retire_dest_idx_o,
	output core_pkg::preg_t                 retire_dest_tag_o,
	output core_pkg::preg_t                 retire_old_tag_o,
	output core_pkg::status_t               status_o
);

	// ====================
	// internal nets
	// ====================
	logic [arch_pkg::AREG_IDX_W-1:0] id_ra_idx;
	logic [arch_pkg::AREG_IDX_W-1:0] id_rb_idx;
	logic [arch_pkg::AREG_IDX_W-1:0] id_dest_idx;
	logic                            id_halt;
	logic                            id_illegal;
	logic                            dispatch_en;  // rob write
	logic                            alloc_en;     // map write, free list pop
	logic                            rob_full;
	logic                            rob_halted;
	logic                            fl_empty;
	logic                            rob_free_en;  // retire with a dest
	core_pkg::preg_t                 fl_head_tag;  // Tnew
	core_pkg::preg_t                 mt_old_tag;   // Told
	core_pkg::preg_t                 rob_old_tag;  // Told leaving at retire

	assign rn_dest_tag_o    = fl_head_tag;
	assign retire_old_tag_o = rob_old_tag;

	id_stage i_id_stage (
		.inst_vld_i       (inst_vld_i),
		.inst_ir_i        (inst_ir_i),
		.rob_full_i       (rob_full),
		.fl_empty_i       (fl_empty),
		.halted_i         (rob_halted),
		.ra_idx_o         (id_ra_idx),
		.rb_idx_o         (id_rb_idx),
		.dest_idx_o       (id_dest_idx),
		.halt_o           (id_halt),
		.illegal_o        (id_illegal),
		.dispatch_en_o    (dispatch_en),
		.alloc_en_o       (alloc_en),
		.dispatch_stall_o (dispatch_stall_o)
	);

	map_table #(.PRF_NUM(PRF_NUM)) i_map_table (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.ra_idx_i   (id_ra_idx),
		.rb_idx_i   (id_rb_idx),
		.dest_idx_i (id_dest_idx),
		.alloc_en_i (alloc_en),
		.new_tag_i  (fl_head_tag),
		.opa_tag_o  (rn_opa_tag_o),
		.opb_tag_o  (rn_opb_tag_o),
		.old_tag_o  (mt_old_tag)
	);

	free_list #(.PRF_NUM(PRF_NUM)) i_free_list (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.alloc_en_i (alloc_en),
		.free_en_i  (rob_free_en),
		.free_tag_i (rob_old_tag), // recycled at retire
		.head_tag_o (fl_head_tag),
		.empty_o    (fl_empty)
	);

	rob #(.ROB_DEPTH(ROB_DEPTH)) i_rob (
		.clk                (clk),
		.rst_n_i            (rst_n_i),
		.dispatch_en_i      (dispatch_en),
		.dest_idx_i         (id_dest_idx),
		.halt_i             (id_halt),
		.illegal_i          (id_illegal),
		.new_tag_i          (fl_head_tag),
		.old_tag_i          (mt_old_tag),
		.complete_vld_i     (complete_vld_i),
		.complete_rob_idx_i (complete_rob_idx_i),
		.tail_idx_o         (rn_rob_idx_o),
		.full_o             (rob_full),
		.halted_o           (rob_halted),
		.retire_vld_o       (retire_vld_o),
		.retire_dest_idx_o  (retire_dest_idx_o),
		.retire_dest_tag_o  (retire_dest_tag_o),
		.retire_old_tag_o   (rob_old_tag),
		.free_en_o          (rob_free_en),
		.status_o           (status_o)
	);

endmodule

//--- tests/tb_rename_core.sv
`timescale 1ns/1ns

module tb_rename_core;

	localparam int PRF_NUM     = 40;
	localparam int ROB_DEPTH   = 16;
	localparam int ROB_IDX_W   = $clog2(ROB_DEPTH);
	localparam int TOTAL_INSNS = 46; // 1 + 6 + 8 + 9 + 17 + 5 words offered over all tests
	localparam int WAIT_LIMIT  = 40; // cycles allowed for a stall, drain or halt

	logic                            clk;
	logic                            rst_n_i;
	logic                            inst_vld_i;
	logic [31:0]                     inst_ir_i;
	logic                            complete_vld_i;
	logic [ROB_IDX_W-1:0]            complete_rob_idx_i;
	logic                            dispatch_stall_o;
	core_pkg::preg_t                 rn_dest_tag_o;
	core_pkg::preg_t                 rn_opa_tag_o;
	core_pkg::preg_t                 rn_opb_tag_o;
	logic [ROB_IDX_W-1:0]            rn_rob_idx_o;
	logic                            retire_vld_o;
	logic [arch_pkg::AREG_IDX_W-1:0] retire_dest_idx_o;
	core_pkg::preg_t                 retire_dest_tag_o;
	core_pkg::preg_t                 retire_old_tag_o;
	core_pkg::status_t               status_o;

	// ====================
	// reference model
	// ====================
	core_pkg::preg_t   map_m [32];   // arch reg -> live tag
	core_pkg::preg_t   free_q [$];   // free tags in pop order
	int                ord_q [$];    // ROB slots in dispatch order
	logic [4:0]        m_dest [ROB_DEPTH];
	core_pkg::preg_t   m_new [ROB_DEPTH];
	core_pkg::preg_t   m_old [ROB_DEPTH];
	logic              m_done [ROB_DEPTH];
	logic              m_halt [ROB_DEPTH];
	logic              m_ill [ROB_DEPTH];
	int                rob_tail;
	logic              m_halted;
	core_pkg::status_t exp_status;

	integer      seed = 10399;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_ok = 0;
	logic [31:0] cur_ir;  // word on inst_ir_i
	logic        ret_pend; // retire seen at negedge and applied at the edge
	logic        exp_ret;
	int          ret_slot;

	rename_core #(.PRF_NUM(PRF_NUM), .ROB_DEPTH(ROB_DEPTH)) i_rename_core (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
		errors++;
	endtask

	task automatic do_reset();
		@(posedge clk);
		rst_n_i        <= 1'b0;
		inst_vld_i     <= 1'b0;
		complete_vld_i <= 1'b0;
		repeat (4) @(posedge clk);
		rst_n_i <= 1'b1;
		for (int i = 0; i < 32; i++)
			map_m[i] = core_pkg::preg_t'(i); // identity map
		free_q.delete();
		for (int t = 32; t < PRF_NUM; t++)
			free_q.push_back(core_pkg::preg_t'(t));
		ord_q.delete();
		rob_tail   = 0;
		m_halted   = 1'b0;
		exp_status = core_pkg::NO_ERROR;
		@(negedge clk);
	endtask

	// alpha subset rules with use flags for the sources
	task automatic decode_word(input logic [31:0] ir, output logic [4:0] ra,
		output logic [4:0] rb, output logic [4:0] dest, output logic use_a,
		output logic use_b, output logic halt, output logic ill);
		logic [5:0] opc;
		opc   = ir[31:26];
		ra    = ir[25:21];
		rb    = ir[20:16];
		dest  = arch_pkg::ZERO_REG;
		use_a = 1'b0;
		use_b = 1'b0;
		halt  = 1'b0;
		ill   = 1'b0;
		if (opc == arch_pkg::OP_INTA || opc == arch_pkg::OP_INTL ||
			opc == arch_pkg::OP_INTS || opc == arch_pkg::OP_INTM) begin
			use_a = 1'b1;
			use_b = 1'b1;
			dest  = ir[4:0]; // rc
		end else if (opc == arch_pkg::OP_LDQ) begin
			use_b = 1'b1; // base only
			dest  = ir[25:21];
		end else if (opc == arch_pkg::OP_PAL && ir[25:0] == arch_pkg::PAL_HALT) begin
			halt = 1'b1;
		end else begin
			ill = 1'b1;
		end
	endtask

	// operate or LDQ with a real destination
	function automatic logic [31:0] rand_writer();
		logic [31:0] r;
		logic [4:0]  rd;
		int          kind;
		r    = $random(seed);
		rd   = r[4:0] % 5'd31; // never r31
		kind = r[17:15] % 5;
		if (kind == 4)
			return {arch_pkg::OP_LDQ, rd, r[14:10], r[31:16]};
		return {arch_pkg::OP_INTA + kind[5:0], r[9:5], r[14:10], r[30:20], rd};
	endfunction

	function automatic logic [31:0] no_dest_word();
		logic [31:0] r;
		r = $random(seed);
		return {arch_pkg::OP_INTL, r[4:0], r[9:5], 11'h0, arch_pkg::ZERO_REG};
	endfunction

	task automatic offer(input logic [31:0] ir);
		@(posedge clk);
		inst_vld_i <= 1'b1;
		inst_ir_i  <= ir;
		cur_ir      = ir;
		@(negedge clk);
	endtask

	// called at a negedge with the word held and waits out any stall
	task automatic take();
		logic [4:0] ra;
		logic [4:0] rb;
		logic [4:0] dest;
		logic       use_a;
		logic       use_b;
		logic       halt;
		logic       ill;
		logic       taken;
		int         waited;
		int         slot;
		decode_word(cur_ir, ra, rb, dest, use_a, use_b, halt, ill);
		waited = 0;
		while (dispatch_stall_o !== 1'b0 && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		taken = (dispatch_stall_o === 1'b0);
		if (!taken) begin
			$display("dispatch stall did not clear within %0d cycles", WAIT_LIMIT);
			errors++;
		end else begin
			if (rn_rob_idx_o !== rob_tail[ROB_IDX_W-1:0])
				report_value("rn_rob_idx_o", rn_rob_idx_o, rob_tail);
			if (use_a && rn_opa_tag_o !== map_m[ra])
				report_value("rn_opa_tag_o", rn_opa_tag_o, map_m[ra]);
			if (use_b && rn_opb_tag_o !== map_m[rb])
				report_value("rn_opb_tag_o", rn_opb_tag_o, map_m[rb]);
			if (dest != arch_pkg::ZERO_REG && free_q.size() == 0) begin
				$display("writer dispatched although no free tag is left");
				errors++;
			end else if (dest != arch_pkg::ZERO_REG && rn_dest_tag_o !== free_q[0]) begin
				report_value("rn_dest_tag_o", rn_dest_tag_o, free_q[0]);
			end
		end
		@(posedge clk); // dispatch edge
		inst_vld_i <= 1'b0;
		if (taken) begin
			slot         = rob_tail;
			m_dest[slot] = dest;
			m_old[slot]  = map_m[dest]; // Told
			m_new[slot]  = map_m[dest];
			m_done[slot] = 1'b0;
			m_halt[slot] = halt;
			m_ill[slot]  = ill;
			if (dest != arch_pkg::ZERO_REG && free_q.size() > 0) begin
				m_new[slot] = free_q.pop_front();
				map_m[dest] = m_new[slot];
			end
			ord_q.push_back(slot);
			rob_tail = (rob_tail + 1) % ROB_DEPTH;
		end
	endtask

	task automatic dispatch(input logic [31:0] ir);
		offer(ir);
		take();
	endtask

	task automatic complete(input int slot);
		@(posedge clk);
		complete_vld_i     <= 1'b1;
		complete_rob_idx_i <= slot[ROB_IDX_W-1:0];
		@(posedge clk); // completion edge
		complete_vld_i <= 1'b0;
		m_done[slot]    = 1'b1;
	endtask

	// completes every outstanding entry in shuffled order
	task automatic complete_shuffled();
		int idx [$];
		int j;
		int t;
		foreach (ord_q[i])
			if (!m_done[ord_q[i]])
				idx.push_back(ord_q[i]);
		for (int i = idx.size() - 1; i > 0; i--) begin
			j      = $unsigned($random(seed)) % (i + 1);
			t      = idx[i];
			idx[i] = idx[j];
			idx[j] = t;
		end
		foreach (idx[i])
			complete(idx[i]);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (ord_q.size() != 0 && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (ord_q.size() != 0) begin
			$display("ROB did not drain, %0d entries still waiting", ord_q.size());
			errors++;
		end
	endtask

	task automatic wait_halted();
		int waited;
		waited = 0;
		while (!m_halted && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!m_halted) begin
			$display("halting entry did not retire within %0d cycles", WAIT_LIMIT);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			tests_ok++;
			$display("test %s: ok", name);
		end else
			$display("test %s: %0d errors", name, errors - err_start);
	endtask

	// ====================
	// retire monitor
	// ====================
	always begin
		@(negedge clk);
		ret_pend = 1'b0;
		if (rst_n_i === 1'b1) begin
			ret_slot = (ord_q.size() > 0) ? ord_q[0] : 0;
			exp_ret  = (ord_q.size() > 0) && m_done[ret_slot] && !m_halted; // oldest only
			if (retire_vld_o !== exp_ret) begin
				report_value("retire_vld_o", retire_vld_o, exp_ret);
			end else if (exp_ret) begin
				ret_pend = 1'b1;
				if (retire_dest_idx_o !== m_dest[ret_slot])
					report_value("retire_dest_idx_o", retire_dest_idx_o, m_dest[ret_slot]);
				if (m_dest[ret_slot] != arch_pkg::ZERO_REG) begin
					if (retire_dest_tag_o !== m_new[ret_slot])
						report_value("retire_dest_tag_o", retire_dest_tag_o, m_new[ret_slot]);
					if (retire_old_tag_o !== m_old[ret_slot])
						report_value("retire_old_tag_o", retire_old_tag_o, m_old[ret_slot]);
				end
			end
			if (status_o !== exp_status)
				report_value("status_o", status_o, exp_status);
		end
		@(posedge clk);
		if (ret_pend) begin
			ret_slot = ord_q.pop_front();
			if (m_dest[ret_slot] != arch_pkg::ZERO_REG)
				free_q.push_back(m_old[ret_slot]); // Told back at the tail
			if (m_ill[ret_slot]) begin
				m_halted   = 1'b1;
				exp_status = core_pkg::HALTED_ON_ILLEGAL;
			end else if (m_halt[ret_slot]) begin
				m_halted   = 1'b1;
				exp_status = core_pkg::HALTED_ON_HALT;
			end
		end
	end

	initial begin
		repeat (TOTAL_INSNS * 50) @(posedge clk);
		$display("watchdog expired after %0d cycles", TOTAL_INSNS * 50);
		$display("=== FAIL ===");
		$finish;
	end

	// ====================
	// directed tests
	// ====================
	task automatic reset_and_first();
		int e;
		e = errors;
		do_reset();
		if (dispatch_stall_o !== 1'b0)
			report_value("dispatch_stall_o", dispatch_stall_o, 0);
		if (retire_vld_o !== 1'b0)
			report_value("retire_vld_o", retire_vld_o, 0);
		offer({arch_pkg::OP_INTA, 5'd1, 5'd2, 11'h020, 5'd3}); // addq r1, r2, r3
		if (rn_dest_tag_o !== 6'd32)
			report_value("rn_dest_tag_o", rn_dest_tag_o, 32);
		if (rn_opa_tag_o !== 6'd1)
			report_value("rn_opa_tag_o", rn_opa_tag_o, 1);
		if (rn_opb_tag_o !== 6'd2)
			report_value("rn_opb_tag_o", rn_opb_tag_o, 2);
		if (rn_rob_idx_o !== '0)
			report_value("rn_rob_idx_o", rn_rob_idx_o, 0);
		take();
		complete(0);
		wait_drain();
		end_test("reset_and_first", e);
	endtask

	task automatic rename_chain();
		int e;
		e = errors;
		do_reset();
		repeat (6) dispatch(rand_writer());
		for (int s = 0; s < 6; s++)
			complete(s); // old tags are checked as each one retires
		wait_drain();
		end_test("rename_chain", e);
	endtask

	task automatic random_completion();
		int e;
		e = errors;
		repeat (8) dispatch(rand_writer()); // two left over and six recycled
		complete_shuffled();
		wait_drain();
		end_test("random_completion", e);
	endtask

	task automatic free_list_stall();
		int e;
		e = errors;
		do_reset();
		repeat (8) dispatch(rand_writer());
		offer(rand_writer()); // ninth writer, no tag left
		if (dispatch_stall_o !== 1'b1)
			report_value("dispatch_stall_o", dispatch_stall_o, 1);
		complete(ord_q[0]);
		@(negedge clk);
		take();
		complete_shuffled();
		wait_drain();
		end_test("free_list_stall", e);
	endtask

	task automatic rob_full_stall();
		int e;
		e = errors;
		do_reset();
		repeat (ROB_DEPTH) dispatch(no_dest_word());
		offer(no_dest_word());
		if (dispatch_stall_o !== 1'b1)
			report_value("dispatch_stall_o", dispatch_stall_o, 1);
		complete(ord_q[0]);
		@(negedge clk);
		take(); // slot 0 again
		complete_shuffled();
		wait_drain();
		end_test("rob_full_stall", e);
	endtask

	task automatic halt_and_illegal();
		int e;
		e = errors;
		do_reset();
		dispatch(rand_writer());
		dispatch(32'h0000_0000); // call_pal halt
		dispatch(rand_writer());
		complete(2); // younger ones complete first but stay behind the halt
		complete(1);
		complete(0);
		wait_halted();
		offer(rand_writer());
		repeat (10) begin
			if (dispatch_stall_o !== 1'b1)
				report_value("dispatch_stall_o", dispatch_stall_o, 1);
			@(negedge clk);
		end
		if (status_o !== core_pkg::HALTED_ON_HALT)
			report_value("status_o", status_o, core_pkg::HALTED_ON_HALT);
		do_reset();
		dispatch(32'h0400_0000); // opcode 0x01
		complete(0);
		wait_halted();
		if (status_o !== core_pkg::HALTED_ON_ILLEGAL)
			report_value("status_o", status_o, core_pkg::HALTED_ON_ILLEGAL);
		if (dispatch_stall_o !== 1'b1)
			report_value("dispatch_stall_o", dispatch_stall_o, 1);
		end_test("halt_and_illegal", e);
	endtask

	initial begin
		rst_n_i            = 1'b0;
		inst_vld_i         = 1'b0;
		inst_ir_i          = '0;
		complete_vld_i     = 1'b0;
		complete_rob_idx_i = '0;
		cur_ir             = '0;
		ret_pend           = 1'b0;
		m_halted           = 1'b0;
		exp_status         = core_pkg::NO_ERROR;
		rob_tail           = 0;

		reset_and_first();
		rename_chain();
		random_completion();
		free_list_stall();
		rob_full_stall();
		halt_and_illegal();

		$display("tests run %0d, passed %0d, errors %0d", tests_run, tests_ok, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- tb.f
common/arch_pkg.sv
common/core_pkg.sv
source/id_stage.sv
rename/map_table.sv
rename/free_list.sv
rob/rob.sv
source/rename_core.sv
tests/tb_rename_core.sv
